//--- flow_buf_patterns.txt
# cmd value count, value in hex and count in decimal
# P pops count pointers from value up, R releases count pointers from value up
# C checks the settled free count, I re-inits the list, W idles count cycles
C 10 1
P 0 13
C 3 1
P d 3
C 0 1
R 7 1
R 2 1
R b 1
C 3 1
P 7 1
P 2 1
P b 1
C 0 1
R 5 1
R 9 1
C 2 1
R 3 1
P 5 1
R c 1
P 9 1
R 0 1
P 3 1
P c 1
P 0 1
C 0 1
R 4 2
P 4 1
C 1 1
W 0 5
I 0 1
C 10 1
P 0 16
C 0 1

//--- flow_buf_top.f
+incdir+.
flow_buf_pkg.sv
buf_ram_fifo.sv
buf_prefetch_fifo.sv
flow_free_list.sv
buf_usage_counter.sv
flow_buf_top.sv
tb_flow_buf_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flow_buf_top.f --top-module tb_flow_buf_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi

//--- tb_flow_buf_top.sv
`timescale 1ns/1ps
`include "flow_buf_macros.svh"

module tb_flow_buf_top;

    localparam int TIMEOUT_CYCLES = 2000;     // Pattern run needs a few hundred cycles
    localparam int SETTLE_CYCLES  = 4;        // A release reaches the count in three

    logic                   clk;
    logic                   arst_n;
    logic                   freeb_init;
    flow_buf_pkg::rel_req_t rel_req;
    logic                   free_buf_rd;
    flow_buf_pkg::buf_ptr_t free_buf_ptr;
    logic                   freeb_empty;
    logic                   freeb_init_done;
    flow_buf_pkg::buf_cnt_t free_count;
    logic                   low_water;

    flow_buf_pkg::buf_ptr_t ref_q [$];        // Expected pop order
    int     model_cnt;                        // Writes since flush minus pops
    int     cycles;
    int     mism_cnt;
    int     other_cnt;
    integer seed;

    flow_buf_top DUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .freeb_init      (freeb_init),
        .rel_req         (rel_req),
        .free_buf_rd     (free_buf_rd),
        .free_buf_ptr    (free_buf_ptr),
        .freeb_empty     (freeb_empty),
        .freeb_init_done (freeb_init_done),
        .free_count      (free_count),
        .low_water       (low_water)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                    // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Inputs change 2 ns after the edge, strobes drop after one cycle
    task automatic next_cycle();
        @(posedge clk);
        #2;
        free_buf_rd = 1'b0;
        rel_req     = '0;
    endtask

    task automatic compare_hex(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h at %0d ns", name, got, exp, $time);
            mism_cnt++;
        end
    endtask

    task automatic load_reference();
        ref_q.delete();
        for (int i = 0; i < `FB_LIST_DEPTH; i++)
            ref_q.push_back(flow_buf_pkg::buf_ptr_t'(i));   // Init fills 0 upward
        model_cnt = `FB_LIST_DEPTH;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (freeb_init_done !== 1'b1 && n < `FB_LIST_DEPTH + 4) begin
            next_cycle();
            n++;
        end
        if (freeb_init_done !== 1'b1) begin
            $display("freeb_init_done did not rise within %0d cycles", `FB_LIST_DEPTH + 4);
            other_cnt++;
        end
    endtask

    task automatic release_ptr(input flow_buf_pkg::buf_ptr_t p);
        if (rel_req.valid)
            next_cycle();                     // One release per cycle
        rel_req = '{valid: 1'b1, ptr: p};     // May share the cycle with a pop
        ref_q.push_back(p);
        model_cnt++;
    endtask

    task automatic pop_check(input flow_buf_pkg::buf_ptr_t exp);
        flow_buf_pkg::buf_ptr_t ref_ptr;
        int gap;
        while (freeb_empty)
            next_cycle();                     // Head not ready yet
        if (ref_q.size() == 0) begin
            $display("Pattern pops 0x%h but the reference queue is empty", exp);
            other_cnt++;
        end else begin
            ref_ptr = ref_q.pop_front();
            if (ref_ptr != exp) begin
                $display("Pattern expects 0x%h where the reference queue holds 0x%h",
                         exp, ref_ptr);
                other_cnt++;
            end
        end
        compare_hex("free_buf_ptr", 8'(free_buf_ptr), 8'(exp));
        free_buf_rd = 1'b1;
        model_cnt--;
        next_cycle();
        gap = int'({$random(seed)} % 3);      // Idle gap between pops
        repeat (gap) next_cycle();
    endtask

    task automatic settle_and_check_count(input logic [7:0] val);
        flow_buf_pkg::buf_cnt_t last_cnt;
        logic last_empty;
        logic exp_low;
        int   stable;
        exp_low = (int'(val) <= `FB_LOW_WATER);
        if (int'(val) != model_cnt) begin
            $display("Pattern count %0d differs from the reference count %0d",
                     val, model_cnt);
            other_cnt++;
        end
        stable     = 0;
        last_cnt   = free_count;
        last_empty = freeb_empty;
        while (stable < SETTLE_CYCLES) begin  // Count and head quiet for a while
            next_cycle();
            if (free_count == last_cnt && freeb_empty == last_empty)
                stable++;
            else
                stable = 0;
            last_cnt   = free_count;
            last_empty = freeb_empty;
        end
        compare_hex("free_count", 8'(free_count), val);
        compare_hex("low_water", 8'(low_water), 8'(exp_low));
        compare_hex("freeb_empty", 8'(freeb_empty), 8'(val == 8'h00));  // Empty only at zero
    endtask

    task automatic reinit_list();
        next_cycle();
        freeb_init = 1'b1;
        next_cycle();                         // Sampled while done
        freeb_init = 1'b0;
        if (freeb_init_done !== 1'b0) begin
            $display("freeb_init_done stayed high after an init request");
            other_cnt++;
        end
        load_reference();
        wait_for_done();
    endtask

    task automatic run_command(input byte cmd, input logic [7:0] val, input int rep);
        case (cmd)
            "P": for (int i = 0; i < rep; i++)
                     pop_check(flow_buf_pkg::buf_ptr_t'(val + 8'(i)));
            "R": for (int i = 0; i < rep; i++)
                     release_ptr(flow_buf_pkg::buf_ptr_t'(val + 8'(i)));
            "C": settle_and_check_count(val);
            "I": reinit_list();
            "W": repeat (rep) next_cycle();
            default: begin
                $display("Unknown pattern command %c", cmd);
                other_cnt++;
            end
        endcase
    endtask

    initial begin
        int         fd;
        int         rc;
        string      line;
        byte        cmd;
        logic [7:0] val;
        int         rep;
        seed        = 21;
        mism_cnt    = 0;
        other_cnt   = 0;
        model_cnt   = 0;
        arst_n      = 1'b0;
        freeb_init  = 1'b0;
        rel_req     = '0;
        free_buf_rd = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        compare_hex("freeb_init_done", 8'(freeb_init_done), 8'h00);   // Reset values
        compare_hex("freeb_empty", 8'(freeb_empty), 8'h01);
        compare_hex("low_water", 8'(low_water), 8'h00);
        compare_hex("free_count", 8'(free_count), 8'h00);
        arst_n = 1'b1;
        wait_for_done();
        load_reference();
        fd = $fopen("flow_buf_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open flow_buf_patterns.txt");
            other_cnt++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 1 && line[0] != "#") begin     // Skip blanks and comments
                    rc = $sscanf(line, "%c %h %d", cmd, val, rep);
                    if (rc != 3) begin
                        $display("Pattern line could not be parsed: %s", line);
                        other_cnt++;
                    end else begin
                        run_command(cmd, val, rep);
                    end
                end
            end
            $fclose(fd);
        end
        next_cycle();
        $display("Errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- flow_buf_top.sv
`timescale 1ns/1ps

module flow_buf_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   freeb_init,      // Rebuild request
    input  flow_buf_pkg::rel_req_t rel_req,         // Returned pointer
    input  logic                   free_buf_rd,     // Pop
    output flow_buf_pkg::buf_ptr_t free_buf_ptr,
    output logic                   freeb_empty,
    output logic                   freeb_init_done,
    output flow_buf_pkg::buf_cnt_t free_count,
    output logic                   low_water
);

    flow_buf_pkg::list_event_t list_evt;          // Alloc, fill and flush strobes

    flow_free_list u_free_list (
        .clk             (clk),
        .arst_n          (arst_n),
        .freeb_init      (freeb_init),
        .rel_req         (rel_req),
        .free_buf_rd     (free_buf_rd),
        .free_buf_ptr    (free_buf_ptr),
        .freeb_empty     (freeb_empty),
        .freeb_init_done (freeb_init_done),
        .list_evt        (list_evt)
    );

    buf_usage_counter u_usage_counter (
        .clk        (clk),
        .arst_n     (arst_n),
        .list_evt   (list_evt),
        .free_count (free_count),
        .low_water  (low_water)
    );

endmodule

//--- buf_usage_counter.sv
`timescale 1ns/1ps
`include "flow_buf_macros.svh"

module buf_usage_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  flow_buf_pkg::list_event_t list_evt,
    output flow_buf_pkg::buf_cnt_t    free_count,
    output logic                      low_water
);

    flow_buf_pkg::buf_cnt_t cnt_nxt;

    // Fill and alloc in one cycle cancel
    always_comb begin
        if (list_evt.flush) begin
            cnt_nxt = '0;
        end else begin
            case ({list_evt.fill, list_evt.alloc})
                2'b10:   cnt_nxt = flow_buf_pkg::buf_cnt_t'(free_count + 1'b1);
                2'b01:   cnt_nxt = flow_buf_pkg::buf_cnt_t'(free_count - 1'b1);
                default: cnt_nxt = free_count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            free_count <= '0;
            low_water  <= 1'b0;                              // Low until first flush
        end else begin
            free_count <= cnt_nxt;
            low_water  <= (cnt_nxt <= flow_buf_pkg::buf_cnt_t'(`FB_LOW_WATER));
        end
    end

    a_cnt_max : assert property (@(posedge clk) disable iff (!arst_n)
        free_count <= flow_buf_pkg::buf_cnt_t'(`FB_LIST_DEPTH))
        else $error("buf_usage_counter count above list depth");

endmodule

//--- flow_free_list.sv
`timescale 1ns/1ps

module flow_free_list (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     freeb_init,       // Level, honored when done
    input  flow_buf_pkg::rel_req_t   rel_req,
    input  logic                     free_buf_rd,      // Pop free_buf_ptr
    output flow_buf_pkg::buf_ptr_t   free_buf_ptr,
    output logic                     freeb_empty,
    output logic                     freeb_init_done,
    output flow_buf_pkg::list_event_t list_evt
);

    flow_buf_pkg::init_state_t st_q;
    flow_buf_pkg::init_state_t st_nxt;

    logic                   fifo_flush;       // Both FIFOs held clear
    logic                   init_wr;          // Init fill in progress
    logic                   rel_valid_q;
    flow_buf_pkg::buf_ptr_t rel_ptr_q;
    logic                   fill_q;
    logic                   ram_rd_d1;        // RAM read data lands next cycle

    flow_buf_pkg::buf_ptr_t ram_din;
    flow_buf_pkg::buf_ptr_t ram_dout;
    flow_buf_pkg::buf_ptr_t ram_wptr;
    logic                   ram_wr;
    logic                   ram_rd;
    logic                   ram_empty;
    logic                   ram_full;

    logic pf_wr;
    logic pf_empty;
    logic pf_full;
    logic pf_fullm1;
    logic pop_acc;

    // Next state
    always_comb begin
        st_nxt = st_q;
        case (st_q)
            flow_buf_pkg::INIT_IDLE:  st_nxt = flow_buf_pkg::INIT_RESET;
            flow_buf_pkg::INIT_RESET: st_nxt = flow_buf_pkg::INIT_FILL;
            flow_buf_pkg::INIT_FILL:  if (&ram_wptr) st_nxt = flow_buf_pkg::INIT_DONE;  // Last ptr
            flow_buf_pkg::INIT_DONE:  if (freeb_init) st_nxt = flow_buf_pkg::INIT_IDLE;
            default:                  st_nxt = flow_buf_pkg::INIT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_q            <= flow_buf_pkg::INIT_IDLE;
            fifo_flush      <= 1'b1;                 // FIFOs clear through reset
            init_wr         <= 1'b0;
            rel_valid_q     <= 1'b0;
            fill_q          <= 1'b0;
            ram_rd_d1       <= 1'b0;
            freeb_init_done <= 1'b0;
        end else begin
            st_q            <= st_nxt;
            fifo_flush      <= (st_nxt == flow_buf_pkg::INIT_RESET);
            init_wr         <= (st_nxt == flow_buf_pkg::INIT_FILL);
            rel_valid_q     <= rel_req.valid;
            fill_q          <= ram_wr;               // Count strobe trails the write
            ram_rd_d1       <= ram_rd;
            freeb_init_done <= (st_nxt == flow_buf_pkg::INIT_DONE);
        end
    end

    always_ff @(posedge clk) begin
        rel_ptr_q <= rel_req.ptr;
    end

    // Init writes its own slot index, otherwise the released pointer
    assign ram_din = init_wr ? ram_wptr : rel_ptr_q;
    assign ram_wr  = init_wr | rel_valid_q;

    // Move to prefetch only with room, counting a write already in flight
    assign pf_wr  = ram_rd_d1;
    assign ram_rd = ~init_wr & ~fifo_flush & ~ram_empty
                  & ~((pf_wr & pf_fullm1) | pf_full);

    assign pop_acc = freeb_init_done & free_buf_rd;

    assign list_evt = '{alloc: pop_acc, fill: fill_q, flush: fifo_flush};

    buf_ram_fifo u_ram_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (fifo_flush),
        .wr     (ram_wr),
        .rd     (ram_rd),
        .din    (ram_din),
        .dout   (ram_dout),
        .wptr   (ram_wptr),
        .empty  (ram_empty),
        .full   (ram_full)
    );

    buf_prefetch_fifo u_prefetch_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (fifo_flush),
        .wr     (pf_wr),
        .rd     (pop_acc),
        .din    (ram_dout),
        .dout   (free_buf_ptr),
        .empty  (pf_empty),
        .full   (pf_full),
        .fullm1 (pf_fullm1)
    );

    assign freeb_empty = pf_empty;

    a_no_pop_empty : assert property (@(posedge clk) disable iff (!arst_n)
        pop_acc |-> !pf_empty)
        else $error("flow_free_list pop accepted while empty");

    // A release while the list holds every pointer would overflow the RAM FIFO
    a_no_rel_full : assert property (@(posedge clk) disable iff (!arst_n)
        (rel_valid_q && !init_wr && !fifo_flush) |-> !ram_full)
        else $error("flow_free_list release with the list full");

endmodule

//--- buf_prefetch_fifo.sv
`timescale 1ns/1ps
`include "flow_buf_macros.svh"

module buf_prefetch_fifo (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  wr,
    input  logic                  rd,
    input  flow_buf_pkg::buf_ptr_t din,
    output flow_buf_pkg::buf_ptr_t dout,     // Head entry, combinational
    output logic                  empty,
    output logic                  full,
    output logic                  fullm1     // One slot left
);

    localparam int IDX_W = $clog2(`FB_PREFETCH_DEPTH);

    flow_buf_pkg::buf_ptr_t ent_q [`FB_PREFETCH_DEPTH];   // Payload flops
    logic [IDX_W-1:0] wr_idx_q;                          // Depth is a power of two
    logic [IDX_W-1:0] rd_idx_q;
    logic [IDX_W:0]   cnt_q;

    assign dout   = ent_q[rd_idx_q];
    assign empty  = (cnt_q == '0);
    assign full   = (cnt_q == (IDX_W+1)'(`FB_PREFETCH_DEPTH));
    assign fullm1 = (cnt_q == (IDX_W+1)'(`FB_PREFETCH_DEPTH - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx_q <= '0;
            rd_idx_q <= '0;
            cnt_q    <= '0;
        end else if (flush) begin
            wr_idx_q <= '0;
            rd_idx_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (wr)
                wr_idx_q <= wr_idx_q + 1'b1;
            if (rd)
                rd_idx_q <= rd_idx_q + 1'b1;           // Pop shows next entry
            case ({wr, rd})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !flush)
            ent_q[wr_idx_q] <= din;
    end

    a_no_wr_full : assert property (@(posedge clk) disable iff (!arst_n || flush)
        wr |-> (!full || rd))
        else $error("buf_prefetch_fifo write while full");

endmodule

//--- buf_ram_fifo.sv
`timescale 1ns/1ps
`include "flow_buf_macros.svh"

module buf_ram_fifo (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,       // Synchronous clear of pointers
    input  logic                  wr,
    input  logic                  rd,
    input  flow_buf_pkg::buf_ptr_t din,
    output flow_buf_pkg::buf_ptr_t dout,       // Registered read data
    output flow_buf_pkg::buf_ptr_t wptr,       // Next write slot
    output logic                  empty,
    output logic                  full
);

    flow_buf_pkg::buf_ptr_t mem [`FB_LIST_DEPTH];   // Pointer storage, no reset
    flow_buf_pkg::buf_ptr_t wr_ptr_q;
    flow_buf_pkg::buf_ptr_t rd_ptr_q;
    flow_buf_pkg::buf_cnt_t cnt_q;                  // Entries held

    logic wr_ok;
    logic rd_ok;

    assign wr_ok = wr & ~flush;
    assign rd_ok = rd & ~flush;

    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == flow_buf_pkg::buf_cnt_t'(`FB_LIST_DEPTH));
    assign wptr  = wr_ptr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;                                   // Restart at slot 0
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (wr_ok)
                wr_ptr_q <= flow_buf_pkg::buf_ptr_t'(wr_ptr_q + 1'b1);  // Wraps at depth
            if (rd_ok)
                rd_ptr_q <= flow_buf_pkg::buf_ptr_t'(rd_ptr_q + 1'b1);
            case ({wr_ok, rd_ok})
                2'b10:   cnt_q <= flow_buf_pkg::buf_cnt_t'(cnt_q + 1'b1);
                2'b01:   cnt_q <= flow_buf_pkg::buf_cnt_t'(cnt_q - 1'b1);
                default: cnt_q <= cnt_q;                      // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_ptr_q] <= din;
        if (rd_ok)
            dout <= mem[rd_ptr_q];                            // Valid the cycle after rd
    end

    a_no_wr_full : assert property (@(posedge clk) disable iff (!arst_n)
        wr_ok |-> !full)
        else $error("buf_ram_fifo write while full");

    a_no_rd_empty : assert property (@(posedge clk) disable iff (!arst_n)
        rd_ok |-> !empty)
        else $error("buf_ram_fifo read while empty");

endmodule

//--- flow_buf_pkg.sv
`include "flow_buf_macros.svh"

package flow_buf_pkg;

    typedef logic [`FB_PTR_NBITS-1:0] buf_ptr_t;   // One buffer pointer
    typedef logic [`FB_PTR_NBITS:0]   buf_cnt_t;   // 0 to FB_LIST_DEPTH

    // Pointer returned by the datapath
    typedef struct packed {
        logic     valid;                           // Single cycle strobe
        buf_ptr_t ptr;
    } rel_req_t;

    // Strobes from the free list to the usage counter
    typedef struct packed {
        logic alloc;                               // Pointer popped
        logic fill;                                // Pointer written, one cycle late
        logic flush;                               // FIFOs held clear
    } list_event_t;

    typedef enum logic [1:0] {
        INIT_IDLE,
        INIT_RESET,
        INIT_FILL,
        INIT_DONE
    } init_state_t;

endpackage

//--- flow_buf_macros.svh
`ifndef FLOW_BUF_MACROS_SVH
`define FLOW_BUF_MACROS_SVH

// Buffer pointer width, 16 buffers
`define FB_PTR_NBITS 4

// Every pointer value is one buffer
`define FB_LIST_DEPTH (1 << `FB_PTR_NBITS)

`define FB_PREFETCH_DEPTH 2   // Entries in the prefetch stage

// Free count at or below this raises low water
`define FB_LOW_WATER 3

`endif
